//--- logic/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

	localparam int xlen = 32;

	typedef logic [4:0] reg_addr_t;
	typedef logic [xlen-1:0] word_t;

	// major opcodes of the kept rv32i subset
	typedef enum logic [6:0] {
		op_load   = 7'b0000011,
		op_imm    = 7'b0010011,
		op_store  = 7'b0100011,
		op_reg    = 7'b0110011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111
	} opcode_e;

	// alu_add is zero so a cleared ctrl_t adds
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_slt = 3'd5
	} alu_op_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    branch;
		// result is pc+4
		logic    link;
	} ctrl_t;

	typedef struct packed {
		logic      valid;
		word_t     pc;
		ctrl_t     ctrl;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t     rs1_value;
		word_t     rs2_value;
		word_t     imm;
	} id_ex_t;

	typedef struct packed {
		logic      valid;
		ctrl_t     ctrl;
		reg_addr_t rd;
		word_t     alu_result;
		word_t     store_data;
	} ex_mem_t;

	typedef struct packed {
		logic      reg_write;
		reg_addr_t rd;
		word_t     data;
	} mem_wb_t;

	typedef struct packed {
		logic  valid;
		logic  write;
		word_t addr;
		word_t wdata;
	} dmem_req_t;

	// bypass sources, memory stage first
	typedef struct packed {
		logic      mem_we;
		reg_addr_t mem_rd;
		word_t     mem_value;
		logic      wb_we;
		reg_addr_t wb_rd;
		word_t     wb_value;
	} fwd_t;

endpackage

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import rv_core_pkg::*; #(
	parameter word_t reset_pc = '0
) (
	input  logic  clock,
	input  logic  reset,
	input  logic  stall_front,
	input  logic  freeze,
	input  logic  flush_decode,
	input  logic  redirect,
	input  word_t redirect_pc,
	input  word_t instr,
	output word_t pc,
	output word_t if_pc,
	output word_t if_instr,
	output logic  if_valid
);

	// program counter, redirect wins over the hold
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= reset_pc;
		end else if (!freeze) begin
			if (redirect) begin
				pc <= redirect_pc;
			end else if (!stall_front) begin
				pc <= pc + 32'd4;
			end
		end
	end

	// fetch/decode register
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			if_valid <= 1'b0;
			if_pc    <= '0;
			if_instr <= '0;
		end else if (!freeze) begin
			if (flush_decode) begin
				// wrong-path word
				if_valid <= 1'b0;
				if_instr <= '0;
			end else if (!stall_front) begin
				if_valid <= 1'b1;
				if_pc    <= pc;
				if_instr <= instr;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/decode_control.sv
`timescale 1ns/1ps
`default_nettype none

module decode_control import rv_core_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  word_t     if_pc,
	input  word_t     if_instr,
	input  logic      if_valid,
	input  word_t     rs1_value,
	input  word_t     rs2_value,
	input  logic      stall_front,
	input  logic      freeze,
	input  logic      flush_execute,
	output reg_addr_t rs1,
	output reg_addr_t rs2,
	output logic      jump,
	output word_t     jump_pc,
	output id_ex_t    id_ex
);

	opcode_e    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       uses_rs1;
	logic       uses_rs2;
	ctrl_t      ctrl;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_j;
	word_t      imm;

	function automatic alu_op_e reg_alu_op(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			3'b000:  op = alt ? alu_sub : alu_add;
			3'b010:  op = alu_slt;
			3'b100:  op = alu_xor;
			3'b110:  op = alu_or;
			3'b111:  op = alu_and;
			default: op = alu_add;
		endcase
		return op;
	endfunction

	assign opcode = opcode_e'(if_instr[6:0]);
	assign funct3 = if_instr[14:12];
	assign funct7 = if_instr[31:25];

	////////////////////////////////////////////////////////////
	// immediates
	assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
	assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
	assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
		if_instr[30:25], if_instr[11:8], 1'b0};
	assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
		if_instr[20], if_instr[30:21], 1'b0};

	////////////////////////////////////////////////////////////
	// control decode, funct3 of addi and beq not checked
	always_comb begin
		ctrl     = '0;
		imm      = imm_i;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		if (if_valid) begin
			case (opcode)
				op_reg: begin
					ctrl.alu_op    = reg_alu_op(funct3, funct7[5]);
					ctrl.reg_write = 1'b1;
					uses_rs1       = 1'b1;
					uses_rs2       = 1'b1;
				end
				op_imm: begin
					ctrl.use_imm   = 1'b1;
					ctrl.reg_write = 1'b1;
					uses_rs1       = 1'b1;
				end
				op_load: begin
					ctrl.use_imm   = 1'b1;
					ctrl.reg_write = 1'b1;
					ctrl.mem_read  = 1'b1;
					uses_rs1       = 1'b1;
				end
				op_store: begin
					ctrl.use_imm   = 1'b1;
					ctrl.mem_write = 1'b1;
					imm            = imm_s;
					uses_rs1       = 1'b1;
					uses_rs2       = 1'b1;
				end
				op_branch: begin
					ctrl.branch = 1'b1;
					imm         = imm_b;
					uses_rs1    = 1'b1;
					uses_rs2    = 1'b1;
				end
				op_jal: begin
					ctrl.reg_write = 1'b1;
					ctrl.link      = 1'b1;
					imm            = imm_j;
				end
				default: ;
			endcase
		end
	end

	// unused sources read as x0, so they never stall or forward
	assign rs1 = uses_rs1 ? if_instr[19:15] : '0;
	assign rs2 = uses_rs2 ? if_instr[24:20] : '0;

	// jal reads no sources and is never held by a load-use stall
	assign jump    = if_valid & (opcode == op_jal);
	assign jump_pc = if_pc + imm_j;

	// decode/execute register
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			id_ex <= '0;
		end else if (!freeze) begin
			if (stall_front || flush_execute) begin
				id_ex <= '0;
			end else begin
				id_ex.valid     <= if_valid;
				id_ex.pc        <= if_pc;
				id_ex.ctrl      <= ctrl;
				id_ex.rs1       <= rs1;
				id_ex.rs2       <= rs2;
				id_ex.rd        <= ctrl.reg_write ? if_instr[11:7] : '0;
				id_ex.rs1_value <= rs1_value;
				id_ex.rs2_value <= rs2_value;
				id_ex.imm       <= imm;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_core_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  reg_addr_t rs1,
	input  reg_addr_t rs2,
	input  mem_wb_t   wb,
	output word_t     rs1_value,
	output word_t     rs2_value
);

	// x0 has no storage
	word_t regs [1:31];

	// same-cycle write passes straight to the reader
	function automatic word_t read_port(input reg_addr_t addr, input mem_wb_t w,
		input word_t stored);
		word_t value;
		value = '0;
		if (addr != '0) begin
			if (w.reg_write && w.rd == addr) begin
				value = w.data;
			end else begin
				value = stored;
			end
		end
		return value;
	endfunction

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.reg_write && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	assign rs1_value = read_port(rs1, wb, (rs1 == '0) ? word_t'(0) : regs[rs1]);
	assign rs2_value = read_port(rs2, wb, (rs2 == '0) ? word_t'(0) : regs[rs2]);

endmodule

`default_nettype wire

//--- logic/hazard_control.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_control import rv_core_pkg::*; (
	input  reg_addr_t rs1,
	input  reg_addr_t rs2,
	input  id_ex_t    id_ex,
	input  logic      branch_taken,
	input  logic      jump,
	input  dmem_req_t dmem_req,
	input  logic      dmem_ready,
	output logic      stall_front,
	output logic      flush_decode,
	output logic      flush_execute,
	output logic      freeze
);

	logic load_in_execute;
	logic load_use;

	////////////////////////////////////////////////////////////
	// load-use, one bubble
	assign load_in_execute = id_ex.valid & id_ex.ctrl.mem_read & (id_ex.rd != '0);
	assign load_use        = load_in_execute & ((id_ex.rd == rs1) | (id_ex.rd == rs2));
	assign stall_front     = load_use;

	////////////////////////////////////////////////////////////
	// redirects
	// taken beq kills fetch and decode, jal only the word behind it
	assign flush_decode  = branch_taken | jump;
	assign flush_execute = branch_taken;

	////////////////////////////////////////////////////////////
	// data port back-pressure holds every stage
	assign freeze = dmem_req.valid & ~dmem_ready;

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import rv_core_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  id_ex_t  id_ex,
	input  fwd_t    fwd,
	input  logic    freeze,
	output logic    branch_taken,
	output word_t   branch_pc,
	output ex_mem_t ex_mem
);

	word_t op_a;
	word_t op_b;
	word_t alu_b;
	word_t alu_result;
	word_t result;

	// newest producer last so it overrides
	function automatic word_t forward_operand(input reg_addr_t src, input word_t reg_value,
		input fwd_t f);
		word_t value;
		value = reg_value;
		if (f.wb_we && f.wb_rd != '0 && f.wb_rd == src) begin
			value = f.wb_value;
		end
		if (f.mem_we && f.mem_rd != '0 && f.mem_rd == src) begin
			value = f.mem_value;
		end
		return value;
	endfunction

	////////////////////////////////////////////////////////////
	// operands
	assign op_a  = forward_operand(id_ex.rs1, id_ex.rs1_value, fwd);
	assign op_b  = forward_operand(id_ex.rs2, id_ex.rs2_value, fwd);
	assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : op_b;

	////////////////////////////////////////////////////////////
	// alu
	always_comb begin
		case (id_ex.ctrl.alu_op)
			alu_add: alu_result = op_a + alu_b;
			alu_sub: alu_result = op_a - alu_b;
			alu_and: alu_result = op_a & alu_b;
			alu_or:  alu_result = op_a | alu_b;
			alu_xor: alu_result = op_a ^ alu_b;
			alu_slt: alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
			default: alu_result = op_a + alu_b;
		endcase
	end

	// jal link value
	assign result = id_ex.ctrl.link ? id_ex.pc + 32'd4 : alu_result;

	// beq only
	assign branch_taken = id_ex.valid & id_ex.ctrl.branch & (op_a == op_b);
	assign branch_pc    = id_ex.pc + id_ex.imm;

	////////////////////////////////////////////////////////////
	// execute/memory register
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ex_mem <= '0;
		end else if (!freeze) begin
			ex_mem.valid      <= id_ex.valid;
			ex_mem.ctrl       <= id_ex.ctrl;
			ex_mem.rd         <= id_ex.rd;
			ex_mem.alu_result <= result;
			// store data after bypass
			ex_mem.store_data <= op_b;
		end
	end

endmodule

`default_nettype wire

//--- logic/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage import rv_core_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  ex_mem_t   ex_mem,
	input  logic      freeze,
	input  word_t     dmem_rdata,
	output dmem_req_t dmem_req,
	output fwd_t      fwd,
	output mem_wb_t   wb
);

	word_t wb_data;

	////////////////////////////////////////////////////////////
	// data port, held steady by freeze until ready
	assign dmem_req.valid = ex_mem.valid & (ex_mem.ctrl.mem_read | ex_mem.ctrl.mem_write);
	assign dmem_req.write = ex_mem.ctrl.mem_write;
	assign dmem_req.addr  = ex_mem.alu_result;
	assign dmem_req.wdata = ex_mem.store_data;

	// load data only valid in the ready cycle
	assign wb_data = ex_mem.ctrl.mem_read ? dmem_rdata : ex_mem.alu_result;

	// memory/writeback register
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			wb <= '0;
		end else if (!freeze) begin
			wb.reg_write <= ex_mem.valid & ex_mem.ctrl.reg_write;
			wb.rd        <= ex_mem.rd;
			wb.data      <= wb_data;
		end
	end

	////////////////////////////////////////////////////////////
	// bypass values
	// a load here never has a consumer in execute, the stall keeps them apart
	assign fwd.mem_we    = ex_mem.valid & ex_mem.ctrl.reg_write & ~ex_mem.ctrl.mem_read;
	assign fwd.mem_rd    = ex_mem.rd;
	assign fwd.mem_value = ex_mem.alu_result;
	assign fwd.wb_we     = wb.reg_write;
	assign fwd.wb_rd     = wb.rd;
	assign fwd.wb_value  = wb.data;

endmodule

`default_nettype wire

//--- logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_core_pkg::*; #(
	parameter word_t reset_pc = '0
) (
	input  logic      clock,
	input  logic      reset,
	output word_t     pc,
	input  word_t     instr,
	output dmem_req_t dmem_req,
	input  word_t     dmem_rdata,
	input  logic      dmem_ready
);

	word_t     if_pc;
	word_t     if_instr;
	logic      if_valid;
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t     rs1_value;
	word_t     rs2_value;
	logic      jump;
	word_t     jump_pc;
	id_ex_t    id_ex;
	logic      branch_taken;
	word_t     branch_pc;
	ex_mem_t   ex_mem;
	fwd_t      fwd;
	mem_wb_t   wb;
	logic      stall_front;
	logic      flush_decode;
	logic      flush_execute;
	logic      freeze;
	logic      redirect;
	word_t     redirect_pc;

	// branch in execute is older than jal in decode
	assign redirect    = branch_taken | jump;
	assign redirect_pc = branch_taken ? branch_pc : jump_pc;

	fetch_stage #(.reset_pc(reset_pc)) fetch (
		.clock(clock), .reset(reset),
		.stall_front(stall_front), .freeze(freeze), .flush_decode(flush_decode),
		.redirect(redirect), .redirect_pc(redirect_pc), .instr(instr),
		.pc(pc), .if_pc(if_pc), .if_instr(if_instr), .if_valid(if_valid)
	);

	decode_control decode (
		.clock(clock), .reset(reset),
		.if_pc(if_pc), .if_instr(if_instr), .if_valid(if_valid),
		.rs1_value(rs1_value), .rs2_value(rs2_value),
		.stall_front(stall_front), .freeze(freeze), .flush_execute(flush_execute),
		.rs1(rs1), .rs2(rs2), .jump(jump), .jump_pc(jump_pc), .id_ex(id_ex)
	);

	reg_file regs (
		.clock(clock), .reset(reset), .rs1(rs1), .rs2(rs2), .wb(wb),
		.rs1_value(rs1_value), .rs2_value(rs2_value)
	);

	hazard_control hazards (
		.rs1(rs1), .rs2(rs2), .id_ex(id_ex), .branch_taken(branch_taken), .jump(jump),
		.dmem_req(dmem_req), .dmem_ready(dmem_ready),
		.stall_front(stall_front), .flush_decode(flush_decode),
		.flush_execute(flush_execute), .freeze(freeze)
	);

	execute_stage execute (
		.clock(clock), .reset(reset), .id_ex(id_ex), .fwd(fwd), .freeze(freeze),
		.branch_taken(branch_taken), .branch_pc(branch_pc), .ex_mem(ex_mem)
	);

	mem_wb_stage mem_wb (
		.clock(clock), .reset(reset), .ex_mem(ex_mem), .freeze(freeze),
		.dmem_rdata(dmem_rdata), .dmem_req(dmem_req), .fwd(fwd), .wb(wb)
	);

endmodule

`default_nettype wire

//--- tests/rv_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_assertions import rv_core_pkg::*; (
	input logic      clock,
	input logic      reset,
	input word_t     pc,
	input dmem_req_t dmem_req,
	input logic      dmem_ready
);

	// request fields hold until the ready edge
	property req_held_until_ready;
		@(posedge clock) disable iff (!reset)
		dmem_req.valid && !dmem_ready |=> $stable(dmem_req);
	endproperty

	req_held_check: assert property (req_held_until_ready)
		else $error("data request changed before dmem_ready");

	no_req_in_reset_check: assert property (@(posedge clock) !reset |-> !dmem_req.valid)
		else $error("data request valid during reset");

	pc_aligned_check: assert property (@(posedge clock) disable iff (!reset) pc[1:0] == 2'b00)
		else $error("pc lost word alignment");

endmodule

bind rv_core rv_core_assertions checks (
	.clock(clock), .reset(reset), .pc(pc), .dmem_req(dmem_req), .dmem_ready(dmem_ready)
);

`default_nettype wire

//--- tests/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_core_pkg::*; ();

	localparam word_t reset_pc    = 32'h0000_0400;
	localparam word_t marker_addr = 32'h0000_0100;
	localparam int    prog_len    = 28;

	logic      clock;
	logic      reset;
	word_t     pc;
	word_t     instr;
	dmem_req_t dmem_req;
	word_t     dmem_rdata;
	logic      dmem_ready;

	word_t     imem [32];
	word_t     dut_mem [64];
	word_t     ref_mem [64];
	int        wait_states [64];
	dmem_req_t exp_req [$];
	string     exp_name [$];
	word_t     exp_marker;
	logic      done;
	int        value_errors;
	int        sequence_errors;

	rv_core #(.reset_pc(reset_pc)) UUT (
		.clock(clock), .reset(reset), .pc(pc), .instr(instr),
		.dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .dmem_ready(dmem_ready)
	);

	// instruction port answers in the same cycle
	assign instr = imem[pc[6:2]];

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// rv32i encodings
	function automatic word_t addi_word(input reg_addr_t rd, input reg_addr_t rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic word_t reg_op_word(input logic [2:0] f3, input logic alt,
		input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
		return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t lw_word(input reg_addr_t rd, input reg_addr_t rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, 7'b0000011};
	endfunction

	function automatic word_t sw_word(input reg_addr_t rs2, input reg_addr_t rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t beq_word(input reg_addr_t rs1, input reg_addr_t rs2,
		input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t jal_word(input reg_addr_t rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic load_program();
		int i;
		// spare slots hold harmless addi x0 words
		for (i = 0; i < 32; i++) begin
			imem[i] = addi_word(5'd0, 5'd0, 12'(i));
		end
		// dependent alu chain
		imem[0]  = addi_word(5'd1, 5'd0, 12'd5);
		imem[1]  = addi_word(5'd2, 5'd0, 12'hffd);
		imem[2]  = reg_op_word(3'b000, 1'b0, 5'd3, 5'd1, 5'd2);
		imem[3]  = reg_op_word(3'b000, 1'b1, 5'd4, 5'd3, 5'd1);
		imem[4]  = reg_op_word(3'b111, 1'b0, 5'd5, 5'd4, 5'd2);
		imem[5]  = reg_op_word(3'b110, 1'b0, 5'd6, 5'd5, 5'd3);
		imem[6]  = reg_op_word(3'b100, 1'b0, 5'd7, 5'd6, 5'd1);
		imem[7]  = reg_op_word(3'b010, 1'b0, 5'd8, 5'd2, 5'd1);
		imem[8]  = sw_word(5'd3, 5'd0, 12'd0);
		imem[9]  = sw_word(5'd7, 5'd0, 12'd4);
		imem[10] = sw_word(5'd8, 5'd0, 12'd8);
		// load then immediate use
		imem[11] = lw_word(5'd9, 5'd0, 12'd16);
		imem[12] = reg_op_word(3'b000, 1'b0, 5'd10, 5'd9, 5'd1);
		imem[13] = sw_word(5'd10, 5'd0, 12'd12);
		imem[14] = addi_word(5'd0, 5'd0, 12'd7);
		imem[15] = sw_word(5'd0, 5'd0, 12'd20);
		// taken beq skips 17, untaken beq falls through, jal skips 21
		imem[16] = beq_word(5'd1, 5'd1, 13'd8);
		imem[17] = sw_word(5'd1, 5'd0, 12'd24);
		imem[18] = beq_word(5'd1, 5'd2, 13'd8);
		imem[19] = sw_word(5'd2, 5'd0, 12'd28);
		imem[20] = jal_word(5'd11, 21'd8);
		imem[21] = sw_word(5'd1, 5'd0, 12'd32);
		imem[22] = sw_word(5'd11, 5'd0, 12'd36);
		imem[23] = lw_word(5'd12, 5'd0, 12'd40);
		imem[24] = sw_word(5'd12, 5'd0, 12'd44);
		imem[25] = addi_word(5'd13, 5'd0, 12'h100);
		imem[26] = sw_word(5'd4, 5'd13, 12'd0);
		imem[27] = jal_word(5'd0, 21'd0);
	endtask

	////////////////////////////////////////////////////////////
	// reference model
	function automatic void record_access(input logic write, input word_t addr,
		input word_t wdata, input word_t at_pc);
		dmem_req_t req;
		string     kind;
		req.valid = 1'b1;
		req.write = write;
		req.addr  = addr;
		req.wdata = wdata;
		if (write) begin
			kind = "store";
		end else begin
			kind = "load";
		end
		exp_req.push_back(req);
		exp_name.push_back($sformatf("%s at pc %h", kind, at_pc));
	endfunction

	function automatic void run_reference();
		word_t regs [32];
		word_t pc_ref;
		word_t next_pc;
		word_t ins;
		word_t a;
		word_t b;
		word_t imm_i;
		word_t addr;
		word_t res;
		logic  write_rd;
		int    steps;
		regs   = '{default: '0};
		pc_ref = reset_pc;
		for (steps = 0; steps < 1000; steps++) begin
			ins      = imem[pc_ref[6:2]];
			a        = regs[ins[19:15]];
			b        = regs[ins[24:20]];
			imm_i    = {{20{ins[31]}}, ins[31:20]};
			next_pc  = pc_ref + 32'd4;
			res      = '0;
			write_rd = 1'b0;
			case (ins[6:0])
				7'b0110011: begin
					write_rd = 1'b1;
					case (ins[14:12])
						3'b000:  res = ins[30] ? a - b : a + b;
						3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						3'b100:  res = a ^ b;
						3'b110:  res = a | b;
						default: res = a & b;
					endcase
				end
				7'b0010011: begin
					write_rd = 1'b1;
					res      = a + imm_i;
				end
				7'b0000011: begin
					addr     = a + imm_i;
					res      = ref_mem[addr[7:2]];
					write_rd = 1'b1;
					record_access(1'b0, addr, '0, pc_ref);
				end
				7'b0100011: begin
					addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
					if (addr == marker_addr) begin
						exp_marker = b;
						return;
					end
					ref_mem[addr[7:2]] = b;
					record_access(1'b1, addr, b, pc_ref);
				end
				7'b1100011: begin
					if (a == b) begin
						next_pc = pc_ref + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
							ins[11:8], 1'b0};
					end
				end
				7'b1101111: begin
					write_rd = 1'b1;
					res      = pc_ref + 32'd4;
					next_pc  = pc_ref + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
						ins[30:21], 1'b0};
				end
				default: ;
			endcase
			if (write_rd && ins[11:7] != 5'd0) begin
				regs[ins[11:7]] = res;
			end
			pc_ref = next_pc;
		end
	endfunction

	////////////////////////////////////////////////////////////
	// compare tasks
	task automatic check_request(input string name, input dmem_req_t expected,
		input dmem_req_t actual);
		string exp_text;
		string act_text;
		if (actual !== expected) begin
			exp_text = $sformatf("write=%0b addr=%h data=%h", expected.write,
				expected.addr, expected.wdata);
			act_text = $sformatf("write=%0b addr=%h data=%h", actual.write,
				actual.addr, actual.wdata);
			$display("[ERROR] %s: expected %s, actual %s", name, exp_text, act_text);
			value_errors++;
		end
	endtask

	task automatic verify_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			value_errors++;
		end
	endtask

	// data memory with random wait states
	initial begin
		int   wait_left;
		int   req_count;
		logic pending;
		dmem_ready = 1'b0;
		dmem_rdata = '0;
		pending    = 1'b0;
		wait_left  = 0;
		req_count  = 0;
		forever begin
			@(negedge clock);
			if (!dmem_req.valid) begin
				pending    = 1'b0;
				dmem_ready = 1'b0;
			end else begin
				// ready last cycle means a new request now
				if (!pending || dmem_ready) begin
					wait_left = wait_states[req_count % 64];
					req_count++;
					pending   = 1'b1;
				end else if (wait_left > 0) begin
					wait_left--;
				end
				dmem_ready = (wait_left == 0);
				dmem_rdata = dut_mem[dmem_req.addr[7:2]];
				if (dmem_ready && dmem_req.write && dmem_req.addr != marker_addr) begin
					dut_mem[dmem_req.addr[7:2]] = dmem_req.wdata;
				end
			end
		end
	end

	// completed transfers against the reference sequence
	initial begin
		dmem_req_t expected;
		dmem_req_t actual;
		string     name;
		done            = 1'b0;
		value_errors    = 0;
		sequence_errors = 0;
		wait (reset);
		verify_word("first fetch address", reset_pc, pc);
		forever begin
			@(posedge clock);
			if (dmem_req.valid && dmem_ready) begin
				actual = dmem_req;
				// write data of a load is don't-care
				if (!actual.write) begin
					actual.wdata = '0;
				end
				if (actual.write && actual.addr == marker_addr) begin
					verify_word("end marker store", exp_marker, actual.wdata);
					if (exp_req.size() != 0) begin
						$display("%0d expected data requests never appeared", exp_req.size());
						sequence_errors += exp_req.size();
					end
					done = 1'b1;
				end else if (exp_req.size() == 0) begin
					$display("unexpected data request to address %h", actual.addr);
					sequence_errors++;
				end else begin
					expected = exp_req.pop_front();
					name     = exp_name.pop_front();
					check_request(name, expected, actual);
				end
			end
		end
	end

	initial begin
		repeat (200 * prog_len) @(posedge clock);
		$display("timeout: the end-marker store never completed");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		int i;
		reset = 1'b0;
		void'($urandom(32'hc622ad2b));
		load_program();
		for (i = 0; i < 64; i++) begin
			dut_mem[i] = $urandom;
			ref_mem[i] = dut_mem[i];
		end
		// ready delay of 0 to 5 cycles per data request
		for (i = 0; i < 64; i++) begin
			wait_states[i] = $urandom % 6;
		end
		run_reference();
		repeat (3) @(negedge clock);
		reset = 1'b1;
		wait (done);
		@(negedge clock);
		$display("errors: %0d value, %0d sequence", value_errors, sequence_errors);
		if (value_errors == 0 && sequence_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rv_core.f
logic/rv_core_pkg.sv
logic/fetch_stage.sv
logic/decode_control.sv
logic/reg_file.sv
logic/hazard_control.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/rv_core.sv
tests/rv_core_assertions.sv
tests/rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rv_core_tb -f rv_core.f \
	--Mdir obj_dir -o rv_core_sim

./obj_dir/rv_core_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
